/* tb.f */
hw/csr_pkg.sv
hw/csr_access_arb.sv
hw/csr_regs.sv
hw/perf_counters.sv
hw/sleep_ctrl.sv
hw/csr_subsystem.sv
verification/csr_subsystem_assertions.sv
verification/tb_csr_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the CSR subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -f tb.f --top-module tb_csr_subsystem \
  -Mdir "$BUILD_DIR" -o sim_csr_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_csr_subsystem" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

/* verification/tb_csr_subsystem.sv */
////////////////////////////////////////////////////////////////////////////
// CSR subsystem testbench
// Random and directed CSR traffic from core and debug, counter events
// and sleep inputs, checked each cycle against a reference model
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_csr_subsystem import csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 8;
  localparam int RAND_OPS        = 120;
  localparam int COUNTER_CYCLES  = 100;
  localparam int INHIBIT_CYCLES  = 30;
  localparam int SLEEP_CYCLES    = 80;
  localparam int ACCEPT_LIMIT    = 16;
  // Directed accesses and reset on top of the loops
  localparam int TEST_CYCLES     = RAND_OPS + COUNTER_CYCLES + 2 * INHIBIT_CYCLES +
                                   SLEEP_CYCLES + 60;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

  localparam int IDX_MSTATUS = 0;
  localparam int IDX_INHIBIT = 1;
  localparam int IDX_SCRATCH = 2;
  localparam int IDX_MEPC    = 3;

  localparam csr_data_t MSTATUS_MASK = 32'h1 << MSTATUS_MIE_BIT;
  localparam csr_data_t INHIBIT_MASK = (32'h1 << INHIBIT_LOAD_BIT) |
                                       (32'h1 << INHIBIT_STORE_BIT);

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         core_req_valid_i;
  csr_req_t     core_req_i;
  logic         core_ready_o;
  logic         core_rsp_valid_o;
  csr_data_t    core_rsp_o;
  logic         dbg_req_valid_i;
  dbg_csr_req_t dbg_req_i;
  logic         dbg_rsp_valid_o;
  csr_data_t    dbg_rsp_o;
  bus_obs_t     bus_i;
  busy_t        busy_i;
  logic         core_firstfetch_i;
  logic         irq_i;
  logic         m_irq_enable_o;
  csr_data_t    mepc_o;
  logic         clock_en_o;
  logic         sleeping_o;

  // Reference model state
  csr_data_t model_csr [4];
  csr_data_t model_load_cnt;
  csr_data_t model_store_cnt;
  logic      model_busy_q;
  logic      exp_core_valid;
  logic      exp_dbg_valid;
  csr_data_t exp_rsp;
  int        rsp_checks = 0;
  integer    seed = 22021;

  csr_subsystem i_dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Value seen by an access before its own update
  function automatic csr_data_t expected_read(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:       return model_csr[IDX_MSTATUS];
      CSR_MCOUNTINHIBIT: return model_csr[IDX_INHIBIT];
      CSR_MSCRATCH:      return model_csr[IDX_SCRATCH];
      CSR_MEPC:          return model_csr[IDX_MEPC];
      CSR_LOAD_CNT:      return model_load_cnt;
      CSR_STORE_CNT:     return model_store_cnt;
      default:           return '0;
    endcase
  endfunction

  function automatic csr_data_t apply_op(input csr_op_e op, input csr_data_t old_v,
                                         input csr_data_t wdata);
    case (op)
      CSR_OP_WRITE: return wdata;
      CSR_OP_SET:   return old_v | wdata;
      CSR_OP_CLEAR: return old_v & ~wdata;
      default:      return old_v;
    endcase
  endfunction

  task automatic model_store(input csr_addr_t addr, input csr_data_t value);
    case (addr)
      CSR_MSTATUS:       model_csr[IDX_MSTATUS] = value & MSTATUS_MASK;
      CSR_MCOUNTINHIBIT: model_csr[IDX_INHIBIT] = value & INHIBIT_MASK;
      CSR_MSCRATCH:      model_csr[IDX_SCRATCH] = value;
      CSR_MEPC:          model_csr[IDX_MEPC]    = value;
      CSR_LOAD_CNT:      model_load_cnt         = value;
      CSR_STORE_CNT:     model_store_cnt        = value;
      default:           ;
    endcase
  endtask

  task automatic model_step();
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
    csr_data_t old_v;
    logic      acc;
    logic      inh_load;
    logic      inh_store;
    acc = dbg_req_valid_i | core_req_valid_i;
    if (dbg_req_valid_i) begin
      op    = dbg_req_i.we ? CSR_OP_WRITE : CSR_OP_NONE;
      addr  = dbg_req_i.addr;
      wdata = dbg_req_i.wdata;
    end else begin
      op    = core_req_i.op;
      addr  = core_req_i.addr;
      wdata = core_req_i.wdata;
    end
    exp_dbg_valid  = dbg_req_valid_i;
    exp_core_valid = acc & ~dbg_req_valid_i;
    // Register value before this edge, counters included
    old_v = expected_read(addr);
    if (acc) begin
      exp_rsp = old_v;
    end
    // Inhibit bits as they stood before this edge
    inh_load  = model_csr[IDX_INHIBIT][INHIBIT_LOAD_BIT];
    inh_store = model_csr[IDX_INHIBIT][INHIBIT_STORE_BIT];
    if (bus_i.req && bus_i.gnt && !bus_i.we && !inh_load) begin
      model_load_cnt = model_load_cnt + 32'd1;
    end
    if (bus_i.req && bus_i.gnt && bus_i.we && !inh_store) begin
      model_store_cnt = model_store_cnt + 32'd1;
    end
    // Counter write overrides a same-cycle event
    if (acc && op != CSR_OP_NONE) begin
      model_store(addr, apply_op(op, old_v, wdata));
    end
    model_busy_q = busy_i.if_busy | busy_i.ctrl_busy | busy_i.lsu_busy;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < 4; i++) begin
        model_csr[i] = '0;
      end
      model_load_cnt  = '0;
      model_store_cnt = '0;
      model_busy_q    = 1'b0;
      exp_core_valid  = 1'b0;
      exp_dbg_valid   = 1'b0;
      exp_rsp         = '0;
    end else begin
      model_step();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s = %h, expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s = %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // Sampled mid-cycle away from the driving edge
  always @(negedge clk_i) begin
    logic exp_busy;
    if (rst_ni) begin
      exp_busy = core_firstfetch_i | model_busy_q;
      check_bit("core_ready_o", core_ready_o, ~dbg_req_valid_i);
      check_bit("core_rsp_valid_o", core_rsp_valid_o, exp_core_valid);
      check_bit("dbg_rsp_valid_o", dbg_rsp_valid_o, exp_dbg_valid);
      if (exp_core_valid) begin
        check_data("core_rsp_o", core_rsp_o, exp_rsp);
        rsp_checks++;
      end
      if (exp_dbg_valid) begin
        check_data("dbg_rsp_o", dbg_rsp_o, exp_rsp);
        rsp_checks++;
      end
      check_bit("m_irq_enable_o", m_irq_enable_o, model_csr[IDX_MSTATUS][MSTATUS_MIE_BIT]);
      check_data("mepc_o", mepc_o, model_csr[IDX_MEPC]);
      check_bit("clock_en_o", clock_en_o, exp_busy | dbg_req_valid_i | irq_i);
      check_bit("sleeping_o", sleeping_o, ~exp_busy);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Holds the core request until an edge with ready high
  task automatic wait_core_accept();
    logic accepted;
    int   waited;
    waited = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = core_ready_o;
      @(posedge clk_i);
      waited++;
      if (waited > ACCEPT_LIMIT) begin
        $display("Core request was not accepted within %0d cycles", ACCEPT_LIMIT);
        stop_on_failure();
      end
    end
    core_req_valid_i <= 1'b0;
  endtask

  task automatic core_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t wdata);
    core_req_valid_i <= 1'b1;
    core_req_i       <= '{op: op, addr: addr, wdata: wdata};
    wait_core_accept();
  endtask

  task automatic dbg_access(input csr_addr_t addr, input logic we, input csr_data_t wdata);
    dbg_req_valid_i <= 1'b1;
    dbg_req_i       <= '{addr: addr, we: we, wdata: wdata};
    @(posedge clk_i);
    dbg_req_valid_i <= 1'b0;
  endtask

  // Core and debug valid together with debug kept for n_dbg cycles
  task automatic contended_access(input csr_op_e op, input csr_addr_t addr,
                                  input csr_data_t wdata, input csr_addr_t dbg_addr,
                                  input logic dbg_we, input csr_data_t dbg_wdata,
                                  input int n_dbg);
    core_req_valid_i <= 1'b1;
    core_req_i       <= '{op: op, addr: addr, wdata: wdata};
    dbg_req_valid_i  <= 1'b1;
    dbg_req_i        <= '{addr: dbg_addr, we: dbg_we, wdata: dbg_wdata};
    repeat (n_dbg) @(posedge clk_i);
    dbg_req_valid_i  <= 1'b0;
    wait_core_accept();
  endtask

  // Random bus traffic with periodic counter reads
  task automatic count_random(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      bus_i <= bus_obs_t'(r[2:0]);
      if (i % 4 == 0) begin
        core_access(CSR_OP_NONE, r[3] ? CSR_STORE_CNT : CSR_LOAD_CNT, '0);
      end else begin
        @(posedge clk_i);
      end
    end
    bus_i <= '0;
  endtask

  task automatic run_sleep_traffic(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      busy_i            <= busy_t'(r[2:0]);
      core_firstfetch_i <= (r[6:4] == 3'd0);
      irq_i             <= (r[9:7] == 3'd0);
      dbg_req_valid_i   <= (r[12:10] == 3'd0);
      dbg_req_i         <= '{addr: CSR_MSCRATCH, we: 1'b0, wdata: r};
      @(posedge clk_i);
    end
    busy_i            <= '0;
    core_firstfetch_i <= 1'b0;
    irq_i             <= 1'b0;
    dbg_req_valid_i   <= 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    rst_ni            = 1'b0;
    core_req_valid_i  = 1'b0;
    core_req_i        = '0;
    dbg_req_valid_i   = 1'b0;
    dbg_req_i         = '0;
    bus_i             = '0;
    busy_i            = '0;
    core_firstfetch_i = 1'b0;
    irq_i             = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Random ops on the full-width registers
    for (int i = 0; i < RAND_OPS; i++) begin
      r = $random(seed);
      w = $random(seed);
      core_access(csr_op_e'(r[1:0]), r[2] ? CSR_MEPC : CSR_MSCRATCH, w);
    end

    // Partially stored and unmapped CSRs
    core_access(CSR_OP_WRITE, CSR_MSTATUS, 32'hFFFF_FFFF);
    core_access(CSR_OP_NONE, CSR_MSTATUS, '0);
    core_access(CSR_OP_CLEAR, CSR_MSTATUS, 32'h0000_0008);
    core_access(CSR_OP_SET, CSR_MSTATUS, 32'h0000_0008);
    core_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF);
    core_access(CSR_OP_NONE, CSR_MCOUNTINHIBIT, '0);
    core_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    core_access(CSR_OP_WRITE, 12'h7C0, 32'h1234_5678);
    core_access(CSR_OP_NONE, 12'h7C0, '0);
    core_access(CSR_OP_SET, 12'h305, 32'hFFFF_FFFF);

    // Debug wins and the held core request completes afterwards
    contended_access(CSR_OP_SET, CSR_MSCRATCH, 32'h0000_00F0,
                     CSR_MSCRATCH, 1'b1, 32'hA5A5_0000, 2);
    dbg_access(CSR_MSCRATCH, 1'b0, 32'hDEAD_BEEF);
    core_access(CSR_OP_NONE, CSR_MSCRATCH, '0);
    dbg_access(CSR_MEPC, 1'b1, 32'h8000_0100);
    contended_access(CSR_OP_CLEAR, CSR_MEPC, 32'h0000_0100, CSR_MEPC, 1'b0, '0, 1);

    // Counters, inhibit, write-load against a same-cycle event
    core_access(CSR_OP_WRITE, CSR_LOAD_CNT, '0);
    core_access(CSR_OP_WRITE, CSR_STORE_CNT, '0);
    count_random(COUNTER_CYCLES);
    core_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0000_0008);
    count_random(INHIBIT_CYCLES);
    core_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0000_0010);
    count_random(INHIBIT_CYCLES);
    core_access(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, '0);
    bus_i <= '{req: 1'b1, gnt: 1'b1, we: 1'b0};
    core_access(CSR_OP_WRITE, CSR_LOAD_CNT, 32'hFFFF_FFFF);
    bus_i <= '{req: 1'b1, gnt: 1'b1, we: 1'b1};
    core_access(CSR_OP_SET, CSR_STORE_CNT, 32'h0000_0100);
    bus_i <= '0;
    core_access(CSR_OP_NONE, CSR_LOAD_CNT, '0);
    core_access(CSR_OP_NONE, CSR_STORE_CNT, '0);

    // Busy, first fetch, irq and debug wake-up
    run_sleep_traffic(SLEEP_CYCLES);
    repeat (3) @(posedge clk_i);

    if (rsp_checks == 0) begin
      $display("No CSR response was observed during the run");
      stop_on_failure();
    end else begin
      $display("%0d responses compared", rsp_checks);
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    stop_on_failure();
  end

endmodule

`default_nettype wire

/* verification/csr_subsystem_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// CSR subsystem protocol assertions
// Debug priority, one-cycle response latency and a single response owner
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module csr_subsystem_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic core_req_valid_i,
  input logic core_ready_o,
  input logic dbg_req_valid_i,
  input logic core_rsp_valid_o,
  input logic dbg_rsp_valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Core stalls while debug is valid
  dbg_priority: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_req_valid_i |-> !core_ready_o)
    else $error("core_ready_o high while a debug request is valid");

  core_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_req_valid_i && core_ready_o) |=> core_rsp_valid_o)
    else $error("core response missing one cycle after acceptance");

  dbg_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_req_valid_i |=> dbg_rsp_valid_o)
    else $error("debug response missing one cycle after acceptance");

  // No response without an accepted request
  rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_rsp_valid_o || dbg_rsp_valid_o) |->
      $past(dbg_req_valid_i || (core_req_valid_i && core_ready_o)))
    else $error("response valid without an accepted request");

  one_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_rsp_valid_o && dbg_rsp_valid_o))
    else $error("core and debug response valid together");

endmodule

bind csr_subsystem csr_subsystem_assertions i_assertions (
  .clk_i            ( clk_i            ),
  .rst_ni           ( rst_ni           ),
  .core_req_valid_i ( core_req_valid_i ),
  .core_ready_o     ( core_ready_o     ),
  .dbg_req_valid_i  ( dbg_req_valid_i  ),
  .core_rsp_valid_o ( core_rsp_valid_o ),
  .dbg_rsp_valid_o  ( dbg_rsp_valid_o  )
);

`default_nettype wire

/* hw/csr_subsystem.sv */
////////////////////////////////////////////////////////////////////////////
// CSR subsystem top level
// Core/debug CSR arbitration, register block, load/store counters and
// the sleep / clock-enable decision
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module csr_subsystem import csr_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Core CSR port
  input  logic         core_req_valid_i,
  input  csr_req_t     core_req_i,
  output logic         core_ready_o,
  output logic         core_rsp_valid_o,
  output csr_data_t    core_rsp_o,
  // Debug CSR port
  input  logic         dbg_req_valid_i,
  input  dbg_csr_req_t dbg_req_i,
  output logic         dbg_rsp_valid_o,
  output csr_data_t    dbg_rsp_o,
  // Observed data bus and core status
  input  bus_obs_t     bus_i,
  input  busy_t        busy_i,
  input  logic         core_firstfetch_i,
  input  logic         irq_i,
  // Status outputs
  output logic         m_irq_enable_o,
  output csr_data_t    mepc_o,
  output logic         clock_en_o,
  output logic         sleeping_o
);

  logic        access_valid;
  csr_access_t access;
  csr_data_t   rdata;
  csr_data_t   load_cnt;
  csr_data_t   store_cnt;
  logic        load_inhibit;
  logic        store_inhibit;
  logic        cnt_we;
  logic        cnt_sel;
  csr_data_t   cnt_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // CSR path
  ////////////////////////////////////////////////////////////////////////////

  csr_access_arb u_arb (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .core_req_valid_i ( core_req_valid_i ),
    .core_req_i       ( core_req_i       ),
    .core_ready_o     ( core_ready_o     ),
    .dbg_req_valid_i  ( dbg_req_valid_i  ),
    .dbg_req_i        ( dbg_req_i        ),
    .access_valid_o   ( access_valid     ),
    .access_o         ( access           ),
    .rdata_i          ( rdata            ),
    .core_rsp_valid_o ( core_rsp_valid_o ),
    .core_rsp_o       ( core_rsp_o       ),
    .dbg_rsp_valid_o  ( dbg_rsp_valid_o  ),
    .dbg_rsp_o        ( dbg_rsp_o        )
  );

  csr_regs u_regs (
    .clk_i           ( clk_i          ),
    .rst_ni          ( rst_ni         ),
    .access_valid_i  ( access_valid   ),
    .access_i        ( access         ),
    .rdata_o         ( rdata          ),
    .load_cnt_i      ( load_cnt       ),
    .store_cnt_i     ( store_cnt      ),
    .m_irq_enable_o  ( m_irq_enable_o ),
    .mepc_o          ( mepc_o         ),
    .load_inhibit_o  ( load_inhibit   ),
    .store_inhibit_o ( store_inhibit  ),
    .cnt_we_o        ( cnt_we         ),
    .cnt_sel_o       ( cnt_sel        ),
    .cnt_wdata_o     ( cnt_wdata      )
  );

  // Counters fed by the observed bus handshake
  perf_counters u_cnt (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .bus_i           ( bus_i         ),
    .load_inhibit_i  ( load_inhibit  ),
    .store_inhibit_i ( store_inhibit ),
    .cnt_we_i        ( cnt_we        ),
    .cnt_sel_i       ( cnt_sel       ),
    .cnt_wdata_i     ( cnt_wdata     ),
    .load_cnt_o      ( load_cnt      ),
    .store_cnt_o     ( store_cnt     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock enable
  ////////////////////////////////////////////////////////////////////////////

  sleep_ctrl u_sleep (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .busy_i            ( busy_i            ),
    .core_firstfetch_i ( core_firstfetch_i ),
    .irq_i             ( irq_i             ),
    .dbg_req_valid_i   ( dbg_req_valid_i   ),
    .clock_en_o        ( clock_en_o        ),
    .sleeping_o        ( sleeping_o        )
  );

endmodule

`default_nettype wire

/* hw/sleep_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Sleep control
// Registers the core busy flags and builds the clock-gate enable
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sleep_ctrl import csr_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  busy_t busy_i,
  input  logic  core_firstfetch_i,
  input  logic  irq_i,
  input  logic  dbg_req_valid_i,
  output logic  clock_en_o,
  output logic  sleeping_o
);

  logic busy_q;
  logic core_busy;

  // One cycle behind the units
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_i.if_busy | busy_i.ctrl_busy | busy_i.lsu_busy;
    end
  end

  // First fetch keeps the core awake
  assign core_busy = core_firstfetch_i ? 1'b1 : busy_q;

  // Debug and irq wake the clock in the same cycle
  assign clock_en_o = core_busy | dbg_req_valid_i | irq_i;
  assign sleeping_o = ~core_busy;

endmodule

`default_nettype wire

/* hw/perf_counters.sv */
////////////////////////////////////////////////////////////////////////////
// Performance counters
// Two wrapping counters for granted loads and stores, each held by its
// inhibit bit and loadable by a CSR write
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module perf_counters import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bus_obs_t  bus_i,
  input  logic      load_inhibit_i,
  input  logic      store_inhibit_i,
  input  logic      cnt_we_i,
  input  logic      cnt_sel_i,
  input  csr_data_t cnt_wdata_i,
  output csr_data_t load_cnt_o,
  output csr_data_t store_cnt_o
);

  csr_data_t               cnt_q [NUM_PERF_CNT];
  logic [NUM_PERF_CNT-1:0] cnt_event;
  logic [NUM_PERF_CNT-1:0] cnt_load;

  // Granted transactions split by direction, gated by inhibit
  assign cnt_event[CNT_IDX_LOAD]  = bus_i.req & bus_i.gnt & ~bus_i.we & ~load_inhibit_i;
  assign cnt_event[CNT_IDX_STORE] = bus_i.req & bus_i.gnt & bus_i.we & ~store_inhibit_i;

  assign cnt_load[CNT_IDX_LOAD]  = cnt_we_i & ~cnt_sel_i;
  assign cnt_load[CNT_IDX_STORE] = cnt_we_i & cnt_sel_i;

  // CSR write has priority over a same-cycle event
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_PERF_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PERF_CNT; i++) begin
        if (cnt_load[i]) begin
          cnt_q[i] <= cnt_wdata_i;
        end else if (cnt_event[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign load_cnt_o  = cnt_q[CNT_IDX_LOAD];
  assign store_cnt_o = cnt_q[CNT_IDX_STORE];

endmodule

`default_nettype wire

/* hw/csr_regs.sv */
////////////////////////////////////////////////////////////////////////////
// CSR register block
// Holds mstatus.MIE, mcountinhibit, mscratch and mepc, applies the
// write/set/clear ops and steers the event counters through write-load
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module csr_regs import csr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Arbitrated access
  input  logic        access_valid_i,
  input  csr_access_t access_i,
  output csr_data_t   rdata_o,
  // Counter values for the read mux
  input  csr_data_t   load_cnt_i,
  input  csr_data_t   store_cnt_i,
  // Status towards the core
  output logic        m_irq_enable_o,
  output csr_data_t   mepc_o,
  // Counter steering
  output logic        load_inhibit_o,
  output logic        store_inhibit_o,
  output logic        cnt_we_o,
  output logic        cnt_sel_o,
  output csr_data_t   cnt_wdata_o
);

  logic      mie_q;
  logic      inhibit_load_q;
  logic      inhibit_store_q;
  csr_data_t mscratch_q;
  csr_data_t mepc_q;

  csr_data_t wdata_new;
  logic      csr_we;

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    case (access_i.addr)
      CSR_MSTATUS:       rdata_o[MSTATUS_MIE_BIT] = mie_q;
      CSR_MCOUNTINHIBIT: begin
        rdata_o[INHIBIT_LOAD_BIT]  = inhibit_load_q;
        rdata_o[INHIBIT_STORE_BIT] = inhibit_store_q;
      end
      CSR_MSCRATCH:      rdata_o = mscratch_q;
      CSR_MEPC:          rdata_o = mepc_q;
      CSR_LOAD_CNT:      rdata_o = load_cnt_i;
      CSR_STORE_CNT:     rdata_o = store_cnt_i;
      // Unmapped reads as zero
      default:           rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Op semantics
  ////////////////////////////////////////////////////////////////////////////

  // SET and CLEAR count as writes even with a zero mask
  assign csr_we = access_valid_i && (access_i.op != CSR_OP_NONE);

  always_comb begin
    case (access_i.op)
      CSR_OP_WRITE: wdata_new = access_i.wdata;
      CSR_OP_SET:   wdata_new = rdata_o | access_i.wdata;
      CSR_OP_CLEAR: wdata_new = rdata_o & ~access_i.wdata;
      default:      wdata_new = rdata_o;
    endcase
  end

  // Stored bits only; everything else is dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q           <= 1'b0;
      inhibit_load_q  <= 1'b0;
      inhibit_store_q <= 1'b0;
      mscratch_q      <= '0;
      mepc_q          <= '0;
    end else if (csr_we) begin
      case (access_i.addr)
        CSR_MSTATUS:       mie_q <= wdata_new[MSTATUS_MIE_BIT];
        CSR_MCOUNTINHIBIT: begin
          inhibit_load_q  <= wdata_new[INHIBIT_LOAD_BIT];
          inhibit_store_q <= wdata_new[INHIBIT_STORE_BIT];
        end
        CSR_MSCRATCH:      mscratch_q <= wdata_new;
        CSR_MEPC:          mepc_q     <= wdata_new;
        default:           ;
      endcase
    end
  end

  // Counter writes go to perf_counters, which owns the storage
  assign cnt_we_o    = csr_we && ((access_i.addr == CSR_LOAD_CNT) ||
                                  (access_i.addr == CSR_STORE_CNT));
  assign cnt_sel_o   = (access_i.addr == CSR_STORE_CNT);
  assign cnt_wdata_o = wdata_new;

  assign m_irq_enable_o  = mie_q;
  assign mepc_o          = mepc_q;
  assign load_inhibit_o  = inhibit_load_q;
  assign store_inhibit_o = inhibit_store_q;

endmodule

`default_nettype wire

/* hw/csr_access_arb.sv */
////////////////////////////////////////////////////////////////////////////
// CSR access arbiter
// Debug requests win over core requests; the read data of the granted
// access is registered with its owner and returned one cycle later
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module csr_access_arb import csr_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Core request, valid/ready
  input  logic         core_req_valid_i,
  input  csr_req_t     core_req_i,
  output logic         core_ready_o,
  // Debug request, always accepted
  input  logic         dbg_req_valid_i,
  input  dbg_csr_req_t dbg_req_i,
  // Access to the register block
  output logic         access_valid_o,
  output csr_access_t  access_o,
  input  csr_data_t    rdata_i,
  // Responses
  output logic         core_rsp_valid_o,
  output csr_data_t    core_rsp_o,
  output logic         dbg_rsp_valid_o,
  output csr_data_t    dbg_rsp_o
);

  logic      rsp_valid_q;
  logic      rsp_dbg_q;
  csr_data_t rsp_data_q;

  // Core stalls while debug is active
  assign core_ready_o   = ~dbg_req_valid_i;
  assign access_valid_o = dbg_req_valid_i | core_req_valid_i;

  // Debug mux, we selects write or plain read
  always_comb begin
    if (dbg_req_valid_i) begin
      access_o.op    = dbg_req_i.we ? CSR_OP_WRITE : CSR_OP_NONE;
      access_o.addr  = dbg_req_i.addr;
      access_o.wdata = dbg_req_i.wdata;
    end else begin
      access_o.op    = core_req_i.op;
      access_o.addr  = core_req_i.addr;
      access_o.wdata = core_req_i.wdata;
    end
  end

  // Response valid and owner tag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_dbg_q   <= 1'b0;
    end else begin
      rsp_valid_q <= access_valid_o;
      rsp_dbg_q   <= dbg_req_valid_i;
    end
  end

  // Old value of the register, captured on the accepting edge
  always_ff @(posedge clk_i) begin
    if (access_valid_o) begin
      rsp_data_q <= rdata_i;
    end
  end

  assign core_rsp_valid_o = rsp_valid_q & ~rsp_dbg_q;
  assign dbg_rsp_valid_o  = rsp_valid_q & rsp_dbg_q;
  assign core_rsp_o       = rsp_data_q;
  assign dbg_rsp_o        = rsp_data_q;

endmodule

`default_nettype wire

/* hw/csr_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// CSR subsystem package
// Widths, CSR addresses, operation codes and the structs shared by the
// arbiter, the register block, the counters and the sleep logic
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package csr_pkg;

  // Basic widths
  localparam int unsigned CSR_ADDR_W   = 12;
  localparam int unsigned CSR_DATA_W   = 32;
  localparam int unsigned NUM_PERF_CNT = 2;

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;

  // Same encoding as the core's CSR op field
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Mapped CSRs
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_LOAD_CNT      = 12'hB03;
  localparam csr_addr_t CSR_STORE_CNT     = 12'hB04;

  // Stored bit positions
  localparam int unsigned MSTATUS_MIE_BIT   = 3;
  localparam int unsigned INHIBIT_LOAD_BIT  = 3;
  localparam int unsigned INHIBIT_STORE_BIT = 4;

  // Counter index, also the cnt_sel encoding
  localparam int unsigned CNT_IDX_LOAD  = 0;
  localparam int unsigned CNT_IDX_STORE = 1;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    csr_addr_t addr;
    logic      we;
    csr_data_t wdata;
  } dbg_csr_req_t;

  // Single access after arbitration
  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_access_t;

  typedef struct packed {
    logic if_busy;
    logic ctrl_busy;
    logic lsu_busy;
  } busy_t;

  // Observed data-bus handshake
  typedef struct packed {
    logic req;
    logic gnt;
    logic we;
  } bus_obs_t;

endpackage

`default_nettype wire
